//--- verilog/pixel_ram_pkg.sv
package pixel_ram_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int PIX_W        = 16;
    localparam int PIX_PER_WORD = 8;
    localparam int WORD_W       = PIX_W * PIX_PER_WORD;

    // one base address expands to a run of four neighbouring pixels
    localparam int QUAD_PIX     = 4;
    localparam int QUADS        = 4;
    localparam int PIX_PER_BEAT = QUADS * QUAD_PIX;

    // two read ports per copy cover the whole beat
    localparam int RAM_COPIES   = 8;
    localparam int NUM_BANKS    = 2;

    //////////////////////////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////////////////////////

    typedef logic [PIX_W-1:0]  pixel_t;
    typedef logic [WORD_W-1:0] word_t;

    // pixel index inside a block, reduced modulo the block size
    typedef logic [15:0] pix_addr_t;
    typedef logic [15:0] word_addr_t;

    // base[0] sits in the low bits of the map word
    typedef struct packed {
        pix_addr_t [QUADS-1:0] base;
    } coord_beat_t;

    // element 4q+k is the pixel at base q plus k
    typedef struct packed {
        pixel_t [PIX_PER_BEAT-1:0] pix;
    } pix_beat_t;

    typedef struct packed {
        logic       we;
        word_addr_t waddr;
        word_t      wdata;
    } bank_wr_t;

    // addresses come already fanned out and wrapped
    typedef struct packed {
        logic                           re;
        pix_addr_t [PIX_PER_BEAT-1:0]   addr;
    } bank_rd_t;

endpackage

//--- verilog/pixel_bank_ram.sv
`timescale 1ns/1ps

module pixel_bank_ram #(
    parameter int WORDS_PER_BLOCK = 16
) (
    input  logic                     clk,
    input  logic                     i_we,
    input  pixel_ram_pkg::word_addr_t i_waddr,
    input  pixel_ram_pkg::word_t     i_wdata,
    input  logic                     i_re,
    input  pixel_ram_pkg::pix_addr_t i_raddr0,
    input  pixel_ram_pkg::pix_addr_t i_raddr1,
    output pixel_ram_pkg::pixel_t    o_rdata0,
    output pixel_ram_pkg::pixel_t    o_rdata1
);
    import pixel_ram_pkg::*;

    localparam int WA_W   = (WORDS_PER_BLOCK > 1) ? $clog2(WORDS_PER_BLOCK) : 1;
    localparam int LANE_W = $clog2(PIX_PER_WORD);

    word_t            mem [WORDS_PER_BLOCK];
    logic [WA_W-1:0]  rd_word0;
    logic [WA_W-1:0]  rd_word1;
    logic [LANE_W-1:0] rd_lane0;
    logic [LANE_W-1:0] rd_lane1;

    // pixel address splits into word index (upper) and lane (lower)
    assign rd_word0 = i_raddr0[LANE_W +: WA_W];
    assign rd_lane0 = i_raddr0[LANE_W-1:0];
    assign rd_word1 = i_raddr1[LANE_W +: WA_W];
    assign rd_lane1 = i_raddr1[LANE_W-1:0];

    // wide write port, one whole DMA word per cycle
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr[WA_W-1:0]] <= i_wdata;
        end
    end

    // narrow read ports, output held while re is low
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata0 <= mem[rd_word0][rd_lane0*PIX_W +: PIX_W];
            o_rdata1 <= mem[rd_word1][rd_lane1*PIX_W +: PIX_W];
        end
    end

endmodule

//--- verilog/pixel_bank.sv
`timescale 1ns/1ps

module pixel_bank #(
    parameter int WORDS_PER_BLOCK = 16
) (
    input  logic                     clk,
    input  pixel_ram_pkg::bank_wr_t  i_wr,
    input  pixel_ram_pkg::bank_rd_t  i_rd,
    output pixel_ram_pkg::pix_beat_t o_pix
);
    import pixel_ram_pkg::*;

    // read ports per RAM copy
    localparam int PORTS = 2;

    pixel_t [PIX_PER_BEAT-1:0] rd_pix;

    //////////////////////////////////////////////////////////////////////
    // replicated copies
    //////////////////////////////////////////////////////////////////////

    // every copy holds the full block, so any pixel can be read
    // from any copy. copy c takes beat slots 2c and 2c+1, which
    // means copies 2q and 2q+1 together serve the four pixels of
    // base q
    for (genvar c = 0; c < RAM_COPIES; c++) begin : g_copy
        pixel_bank_ram #(
            .WORDS_PER_BLOCK (WORDS_PER_BLOCK)
        ) u_ram (
            .clk      (clk),
            .i_we     (i_wr.we),
            .i_waddr  (i_wr.waddr),
            .i_wdata  (i_wr.wdata),
            .i_re     (i_rd.re),
            .i_raddr0 (i_rd.addr[PORTS*c]),
            .i_raddr1 (i_rd.addr[PORTS*c+1]),
            .o_rdata0 (rd_pix[PORTS*c]),
            .o_rdata1 (rd_pix[PORTS*c+1])
        );
    end

    // slot order of the beat is kept as is
    assign o_pix.pix = rd_pix;

endmodule

//--- verilog/pingpong_ctrl.sv
`timescale 1ns/1ps

module pingpong_ctrl #(
    parameter int WORDS_PER_BLOCK  = 16,
    parameter int BLOCKS_PER_FRAME = 3
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    i_frame_start,
    input  logic                    i_dma_valid,
    output logic                    o_dma_ready,
    input  pixel_ram_pkg::word_t    i_dma_data,
    input  logic                    i_block_read,
    output pixel_ram_pkg::bank_wr_t o_wr_a,
    output pixel_ram_pkg::bank_wr_t o_wr_b,
    output logic                    o_rd_bank,
    output logic                    o_rd_ready,
    output logic                    o_frame_done
);
    import pixel_ram_pkg::*;

    localparam int WC_W = (WORDS_PER_BLOCK > 1) ? $clog2(WORDS_PER_BLOCK) : 1;
    localparam int BC_W = $clog2(BLOCKS_PER_FRAME + 1);
    localparam logic [WC_W-1:0] LAST_WORD = WC_W'(WORDS_PER_BLOCK - 1);
    localparam logic [BC_W-1:0] LAST_BLK  = BC_W'(BLOCKS_PER_FRAME - 1);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WAIT_FREE
    } state_t;

    state_t               state;
    logic                 start_d0;
    logic                 start_d1;
    logic                 start_pos;
    logic                 dma_hs;
    logic                 last_word;
    logic [WC_W-1:0]      word_cnt;
    logic [BC_W-1:0]      blk_wr_cnt;
    logic [BC_W-1:0]      blk_rd_cnt;
    logic                 wr_bank;
    logic                 wr_we_a;
    logic                 wr_we_b;
    logic                 wr_last;
    word_addr_t           wr_addr_q;
    word_t                wr_data_q;
    logic [NUM_BANKS-1:0] full;
    logic [NUM_BANKS-1:0] full_nxt;
    logic                 rd_bank_nxt;

    //////////////////////////////////////////////////////////////////////
    // frame start edge
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_d0 <= 1'b0;
            start_d1 <= 1'b0;
        end else begin
            start_d0 <= i_frame_start;
            start_d1 <= start_d0;
        end
    end

    assign start_pos = start_d0 && !start_d1;
    assign dma_hs    = i_dma_valid && o_dma_ready;
    assign last_word = (word_cnt == LAST_WORD);

    //////////////////////////////////////////////////////////////////////
    // write side FSM, word and block counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state       <= IDLE;
            o_dma_ready <= 1'b0;
            word_cnt    <= '0;
            blk_wr_cnt  <= '0;
            wr_bank     <= 1'b0;
        end else if (start_pos) begin
            state       <= WRITE;
            o_dma_ready <= 1'b1;
            word_cnt    <= '0;
            blk_wr_cnt  <= '0;
            wr_bank     <= 1'b0;
        end else begin
            case (state)
                WRITE: begin
                    if (dma_hs && last_word) begin
                        word_cnt    <= '0;
                        wr_bank     <= ~wr_bank;
                        o_dma_ready <= 1'b0;
                        if (blk_wr_cnt == LAST_BLK) begin
                            blk_wr_cnt <= '0;
                            state      <= IDLE;
                        end else begin
                            blk_wr_cnt <= blk_wr_cnt + 1'b1;
                            state      <= WAIT_FREE;
                        end
                    end else if (dma_hs) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                // next bank may still be draining
                WAIT_FREE: begin
                    if (!full[wr_bank]) begin
                        state       <= WRITE;
                        o_dma_ready <= 1'b1;
                    end
                end
                default: begin
                    o_dma_ready <= 1'b0;
                end
            endcase
        end
    end

    // registered write port, steered to the bank being filled
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_we_a <= 1'b0;
            wr_we_b <= 1'b0;
            wr_last <= 1'b0;
        end else begin
            wr_we_a <= dma_hs && !wr_bank;
            wr_we_b <= dma_hs && wr_bank;
            wr_last <= dma_hs && last_word;
        end
    end

    always_ff @(posedge clk) begin
        if (dma_hs) begin
            wr_addr_q <= word_addr_t'(word_cnt);
            wr_data_q <= i_dma_data;
        end
    end

    assign o_wr_a = '{we: wr_we_a, waddr: wr_addr_q, wdata: wr_data_q};
    assign o_wr_b = '{we: wr_we_b, waddr: wr_addr_q, wdata: wr_data_q};

    //////////////////////////////////////////////////////////////////////
    // bank full flags and read side
    //////////////////////////////////////////////////////////////////////

    // full is set as the last word lands in the RAM
    always_comb begin
        full_nxt = full;
        if (wr_last) begin
            full_nxt[wr_we_b] = 1'b1;
        end
        if (i_block_read) begin
            full_nxt[o_rd_bank] = 1'b0;
        end
    end

    assign rd_bank_nxt = o_rd_bank ^ i_block_read;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            full         <= '0;
            o_rd_bank    <= 1'b0;
            o_rd_ready   <= 1'b0;
            blk_rd_cnt   <= '0;
            o_frame_done <= 1'b0;
        end else if (start_pos) begin
            full         <= '0;
            o_rd_bank    <= 1'b0;
            o_rd_ready   <= 1'b0;
            blk_rd_cnt   <= '0;
            o_frame_done <= 1'b0;
        end else begin
            full         <= full_nxt;
            o_rd_bank    <= rd_bank_nxt;
            o_rd_ready   <= full_nxt[rd_bank_nxt];
            o_frame_done <= 1'b0;
            if (i_block_read) begin
                if (blk_rd_cnt == LAST_BLK) begin
                    blk_rd_cnt   <= '0;
                    o_frame_done <= 1'b1;
                end else begin
                    blk_rd_cnt <= blk_rd_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/gather_read.sv
`timescale 1ns/1ps

module gather_read #(
    parameter int WORDS_PER_BLOCK  = 16,
    parameter int COORDS_PER_BLOCK = 8
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       i_rd_bank,
    input  logic                       i_rd_ready,
    input  logic                       i_map_valid,
    output logic                       o_map_ready,
    input  pixel_ram_pkg::coord_beat_t i_map_data,
    output pixel_ram_pkg::bank_rd_t    o_rd,
    input  pixel_ram_pkg::pix_beat_t   i_pix_a,
    input  pixel_ram_pkg::pix_beat_t   i_pix_b,
    output logic                       o_pix_valid,
    input  logic                       i_pix_ready,
    output pixel_ram_pkg::pix_beat_t   o_pix_data,
    output logic                       o_block_read
);
    import pixel_ram_pkg::*;

    localparam int PIXELS_PER_BLOCK = WORDS_PER_BLOCK * PIX_PER_WORD;
    localparam int CC_W = (COORDS_PER_BLOCK > 1) ? $clog2(COORDS_PER_BLOCK) : 1;
    localparam logic [CC_W-1:0] LAST_BEAT = CC_W'(COORDS_PER_BLOCK - 1);

    logic            map_hs;
    logic            s1_valid;
    logic            s1_bank;
    logic            s1_ready;
    logic            out_ready;
    logic [CC_W-1:0] beat_cnt;

    //////////////////////////////////////////////////////////////////////
    // stall logic
    //////////////////////////////////////////////////////////////////////

    assign out_ready = !o_pix_valid || i_pix_ready;
    assign s1_ready  = !s1_valid || out_ready;

    // no intake in the cycle the finished bank is handed back
    assign o_map_ready = i_rd_ready && !o_block_read && s1_ready;
    assign map_hs      = i_map_valid && o_map_ready;

    // fan each base out to base+0..3, wrapping inside the block
    always_comb begin
        o_rd.re = map_hs;
        for (int q = 0; q < QUADS; q++) begin
            for (int k = 0; k < QUAD_PIX; k++) begin
                o_rd.addr[q*QUAD_PIX + k] =
                    pix_addr_t'((32'(i_map_data.base[q]) + k) % PIXELS_PER_BLOCK);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 1 is the RAM output, stage 2 the output register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid    <= 1'b0;
            s1_bank     <= 1'b0;
            o_pix_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= map_hs;
                s1_bank  <= i_rd_bank;
            end
            if (out_ready) begin
                o_pix_valid <= s1_valid;
            end
        end
    end

    // bank mux, the select travels with its beat
    always_ff @(posedge clk) begin
        if (out_ready && s1_valid) begin
            o_pix_data <= s1_bank ? i_pix_b : i_pix_a;
        end
    end

    // beats per block, the pulse frees the bank
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt     <= '0;
            o_block_read <= 1'b0;
        end else begin
            o_block_read <= 1'b0;
            if (map_hs) begin
                if (beat_cnt == LAST_BEAT) begin
                    beat_cnt     <= '0;
                    o_block_read <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/pixel_ram_ctrl.sv
`timescale 1ns/1ps

module pixel_ram_ctrl #(
    parameter int WORDS_PER_BLOCK  = 16,
    parameter int COORDS_PER_BLOCK = 8,
    parameter int BLOCKS_PER_FRAME = 3
) (
    input  logic                       clk,
    input  logic                       rstn,

    // DMA pixel words
    input  logic                       i_dma_valid,
    output logic                       o_dma_ready,
    input  pixel_ram_pkg::word_t       i_dma_data,

    // coordinate map
    input  logic                       i_map_valid,
    output logic                       o_map_ready,
    input  pixel_ram_pkg::coord_beat_t i_map_data,

    // gathered pixels
    output logic                       o_pix_valid,
    input  logic                       i_pix_ready,
    output pixel_ram_pkg::pix_beat_t   o_pix_data,

    input  logic                       i_frame_start,
    output logic                       o_frame_done
);
    import pixel_ram_pkg::*;

    bank_wr_t  wr_a;
    bank_wr_t  wr_b;
    bank_rd_t  rd;
    pix_beat_t pix_a;
    pix_beat_t pix_b;
    logic      rd_bank;
    logic      rd_ready;
    logic      block_read;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    pingpong_ctrl #(
        .WORDS_PER_BLOCK  (WORDS_PER_BLOCK),
        .BLOCKS_PER_FRAME (BLOCKS_PER_FRAME)
    ) u_pingpong_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_frame_start (i_frame_start),
        .i_dma_valid   (i_dma_valid),
        .o_dma_ready   (o_dma_ready),
        .i_dma_data    (i_dma_data),
        .i_block_read  (block_read),
        .o_wr_a        (wr_a),
        .o_wr_b        (wr_b),
        .o_rd_bank     (rd_bank),
        .o_rd_ready    (rd_ready),
        .o_frame_done  (o_frame_done)
    );

    gather_read #(
        .WORDS_PER_BLOCK  (WORDS_PER_BLOCK),
        .COORDS_PER_BLOCK (COORDS_PER_BLOCK)
    ) u_gather_read (
        .clk          (clk),
        .rstn         (rstn),
        .i_rd_bank    (rd_bank),
        .i_rd_ready   (rd_ready),
        .i_map_valid  (i_map_valid),
        .o_map_ready  (o_map_ready),
        .i_map_data   (i_map_data),
        .o_rd         (rd),
        .i_pix_a      (pix_a),
        .i_pix_b      (pix_b),
        .o_pix_valid  (o_pix_valid),
        .i_pix_ready  (i_pix_ready),
        .o_pix_data   (o_pix_data),
        .o_block_read (block_read)
    );

    //////////////////////////////////////////////////////////////////////
    // banks A and B share the read addresses
    //////////////////////////////////////////////////////////////////////

    pixel_bank #(
        .WORDS_PER_BLOCK (WORDS_PER_BLOCK)
    ) u_bank_a (
        .clk   (clk),
        .i_wr  (wr_a),
        .i_rd  (rd),
        .o_pix (pix_a)
    );

    pixel_bank #(
        .WORDS_PER_BLOCK (WORDS_PER_BLOCK)
    ) u_bank_b (
        .clk   (clk),
        .i_wr  (wr_b),
        .i_rd  (rd),
        .o_pix (pix_b)
    );

endmodule

//--- test/pixel_ram_ctrl_assertions.sv
`timescale 1ns/1ps

module pixel_ram_ctrl_assertions (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     o_pix_valid,
    input  logic                     i_pix_ready,
    input  pixel_ram_pkg::pix_beat_t o_pix_data,
    input  logic                     o_frame_done
);

    // a stalled output beat must stay put until it is taken
    a_pix_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        (o_pix_valid && !i_pix_ready) |=> (o_pix_valid && $stable(o_pix_data))
    ) else $error("pixel output changed while stalled");

    // frame done is a single cycle pulse
    a_done_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        o_frame_done |=> !o_frame_done
    ) else $error("frame done held longer than one cycle");

endmodule

bind pixel_ram_ctrl pixel_ram_ctrl_assertions u_assertions (
    .clk          (clk),
    .rstn         (rstn),
    .o_pix_valid  (o_pix_valid),
    .i_pix_ready  (i_pix_ready),
    .o_pix_data   (o_pix_data),
    .o_frame_done (o_frame_done)
);

//--- test/tb_pixel_ram_ctrl.sv
`timescale 1ns/1ps

module tb_pixel_ram_ctrl;
    import pixel_ram_pkg::*;

    localparam int WORDS_PER_BLOCK  = 16;
    localparam int COORDS_PER_BLOCK = 8;
    localparam int BLOCKS_PER_FRAME = 3;
    localparam int PIXELS_PER_BLOCK = WORDS_PER_BLOCK * PIX_PER_WORD;
    // eight blocks go through the DUT over all tests, each far below 500 cycles
    localparam int BLOCKS_RUN = 8;
    localparam int MAX_CYCLES = 500 * BLOCKS_RUN;

    logic        clk;
    logic        rstn;
    logic        i_dma_valid;
    logic        o_dma_ready;
    word_t       i_dma_data;
    logic        i_map_valid;
    logic        o_map_ready;
    coord_beat_t i_map_data;
    logic        o_pix_valid;
    logic        i_pix_ready;
    pix_beat_t   o_pix_data;
    logic        i_frame_start;
    logic        o_frame_done;

    pix_beat_t exp_q[$];
    string     cur_test = "none";
    int        errors = 0;
    int        checks = 0;
    int        cycle = 0;
    int        done_cnt = 0;
    int        accept_cycle = 0;
    int        last_out_cycle = 0;
    int        first_wr_cycle = 0;
    int        bp_mode = 0;
    logic      stall_seen = 1'b0;

    pixel_ram_ctrl #(
        .WORDS_PER_BLOCK  (WORDS_PER_BLOCK),
        .COORDS_PER_BLOCK (COORDS_PER_BLOCK),
        .BLOCKS_PER_FRAME (BLOCKS_PER_FRAME)
    ) i_pixel_ram_ctrl (
        .clk           (clk),
        .rstn          (rstn),
        .i_dma_valid   (i_dma_valid),
        .o_dma_ready   (o_dma_ready),
        .i_dma_data    (i_dma_data),
        .i_map_valid   (i_map_valid),
        .o_map_ready   (o_map_ready),
        .i_map_data    (i_map_data),
        .o_pix_valid   (o_pix_valid),
        .i_pix_ready   (i_pix_ready),
        .o_pix_data    (o_pix_data),
        .i_frame_start (i_frame_start),
        .o_frame_done  (o_frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // pixel n of block b holds b*256+n
    function automatic word_t make_word(input int blk, input int w);
        word_t d;
        for (int l = 0; l < PIX_PER_WORD; l++) begin
            d[l*PIX_W +: PIX_W] = pixel_t'(blk * 256 + w * PIX_PER_WORD + l);
        end
        return d;
    endfunction

    function automatic pix_beat_t expect_beat(input int blk, input coord_beat_t c);
        pix_beat_t e;
        for (int q = 0; q < QUADS; q++) begin
            for (int k = 0; k < 4; k++) begin
                e.pix[q*4 + k] =
                    pixel_t'(blk * 256 + (int'(c.base[q]) + k) % PIXELS_PER_BLOCK);
            end
        end
        return e;
    endfunction

    function automatic coord_beat_t random_beat();
        coord_beat_t c;
        for (int q = 0; q < QUADS; q++) begin
            c.base[q] = pix_addr_t'($urandom % PIXELS_PER_BLOCK);
        end
        return c;
    endfunction

    task automatic check_value(input string what, input logic [255:0] expected,
                               input logic [255:0] actual);
        checks++;
        assert (expected == actual) else begin
            $display("FAILED %s: %s expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            errors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // drivers, all tasks start and end 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic start_frame();
        i_frame_start = 1'b1;
        wait_cycles(2);
        i_frame_start = 1'b0;
        done_cnt = 0;
        check_value("o_dma_ready after frame start", 1, o_dma_ready);
    endtask

    task automatic write_block(input int blk);
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            i_dma_valid = 1'b1;
            i_dma_data  = make_word(blk, w);
            do @(posedge clk); while (!o_dma_ready);
            if (w == 0) begin
                first_wr_cycle = cycle;
            end
            #1;
        end
        i_dma_valid = 1'b0;
    endtask

    task automatic send_beat(input int blk, input coord_beat_t c);
        i_map_valid = 1'b1;
        i_map_data  = c;
        do @(posedge clk); while (!o_map_ready);
        exp_q.push_back(expect_beat(blk, c));
        accept_cycle = cycle;
        #1;
        i_map_valid = 1'b0;
    endtask

    task automatic read_block(input int blk, input int nbeats);
        for (int i = 0; i < nbeats; i++) begin
            send_beat(blk, random_beat());
        end
    endtask

    // wait for every accepted beat to leave the output
    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            wait_cycles(1);
            n++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            $display("ERROR in %s: %0d accepted beats never came out",
                     cur_test, exp_q.size());
            errors++;
        end
        wait_cycles(3);
    endtask

    // 0 keeps i_pix_ready high, 1 randomizes it, 2 holds it low
    initial begin
        i_pix_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            case (bp_mode)
                0:       i_pix_ready = 1'b1;
                1:       i_pix_ready = 1'($urandom % 2);
                default: i_pix_ready = 1'b0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output monitor and cycle limit
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rstn) begin
            if (o_frame_done) begin
                done_cnt++;
            end
            if (i_map_valid && o_pix_valid && !i_pix_ready && !o_map_ready) begin
                stall_seen = 1'b1;
            end
            if (o_pix_valid && i_pix_ready) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    $display("ERROR in %s: output beat with no beat pending", cur_test);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    check_value("pixel beat", exp_q.pop_front(), o_pix_data);
                    last_out_cycle = cycle;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("run stopped at the limit of %0d cycles in %s", MAX_CYCLES, cur_test);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        cur_test = "reset_state";
        check_value("o_dma_ready", 0, o_dma_ready);
        check_value("o_map_ready", 0, o_map_ready);
        check_value("o_pix_valid", 0, o_pix_valid);
        check_value("o_frame_done", 0, o_frame_done);
        repeat (10) begin
            wait_cycles(1);
            check_value("o_dma_ready without start", 0, o_dma_ready);
        end
    endtask

    task automatic test_single_gather();
        coord_beat_t c;
        cur_test = "single_gather";
        c.base[0] = 16'd0;
        c.base[1] = 16'd5;
        c.base[2] = 16'd9;
        c.base[3] = 16'd126;
        start_frame();
        write_block(0);
        send_beat(0, c);
        drain();
        check_value("read latency", 2, last_out_cycle - accept_cycle);
        read_block(0, COORDS_PER_BLOCK - 1);
        drain();
    endtask

    task automatic test_full_frame();
        cur_test = "full_frame";
        start_frame();
        fork
            begin
                for (int b = 0; b < BLOCKS_PER_FRAME; b++) begin
                    write_block(b);
                end
            end
            begin
                for (int b = 0; b < BLOCKS_PER_FRAME; b++) begin
                    read_block(b, COORDS_PER_BLOCK);
                end
            end
        join
        check_value("done before last beat", 0, done_cnt);
        drain();
        check_value("frame done pulses", 1, done_cnt);
    endtask

    task automatic test_output_backpressure();
        cur_test = "output_backpressure";
        stall_seen = 1'b0;
        start_frame();
        write_block(0);
        bp_mode = 2;
        fork
            read_block(0, COORDS_PER_BLOCK);
            begin
                wait_cycles(6);
                bp_mode = 1;
            end
        join
        drain();
        bp_mode = 0;
        wait_cycles(2);
        check_value("o_map_ready low while stalled", 1, stall_seen);
    endtask

    task automatic test_write_backpressure();
        int blk0_cycle;
        cur_test = "write_backpressure";
        blk0_cycle = 0;
        start_frame();
        write_block(0);
        write_block(1);
        fork
            write_block(2);
            begin
                repeat (20) begin
                    @(posedge clk);
                    check_value("o_dma_ready with both banks full", 0, o_dma_ready);
                end
                #1;
                read_block(0, COORDS_PER_BLOCK);
                blk0_cycle = accept_cycle;
                read_block(1, COORDS_PER_BLOCK);
                read_block(2, COORDS_PER_BLOCK);
            end
        join
        drain();
        checks++;
        assert (first_wr_cycle > blk0_cycle) else begin
            $display("ERROR in %s: block 2 was written before block 0 was read", cur_test);
            errors++;
        end
        check_value("frame done pulses", 1, done_cnt);
    endtask

    initial begin
        void'($urandom(30660));
        rstn          = 1'b0;
        i_dma_valid   = 1'b0;
        i_dma_data    = '0;
        i_map_valid   = 1'b0;
        i_map_data    = '0;
        i_frame_start = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        wait_cycles(1);

        test_reset();
        test_single_gather();
        test_full_frame();
        test_output_backpressure();
        test_write_backpressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
verilog/pixel_ram_pkg.sv
verilog/pixel_bank_ram.sv
verilog/pixel_bank.sv
verilog/pingpong_ctrl.sv
verilog/gather_read.sv
verilog/pixel_ram_ctrl.sv
test/pixel_ram_ctrl_assertions.sv
test/tb_pixel_ram_ctrl.sv

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_pixel_ram_ctrl -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
